/* common/cpu_pkg.sv */
// cpu types: word, register index, opcode, shift, alu op, memory command, states, control structs
package cpu_pkg;

	localparam int word_w = 16;

	typedef logic [word_w-1:0] word_t;
	typedef logic [2:0] reg_idx_t;

	typedef enum logic [2:0] {
		opc_load = 3'b011,
		opc_store = 3'b100,
		opc_alu = 3'b101,
		opc_move = 3'b110,
		opc_halt = 3'b111 // only legal with op 00
	} opcode_t;

	typedef enum logic [1:0] {
		sh_none = 2'b00,
		sh_lsl1 = 2'b01,
		sh_lsr1 = 2'b10,
		sh_asr1 = 2'b11
	} shift_t;

	typedef enum logic [1:0] {
		alu_add = 2'b00,
		alu_cmp = 2'b01, // compare is gone, code behaves like add
		alu_and = 2'b10,
		alu_not = 2'b11
	} alu_op_t;

	typedef enum logic [1:0] {
		mem_none = 2'b00,
		mem_read = 2'b01,
		mem_write = 2'b10
	} mem_cmd_t;

	// upper three bits pick the instruction group, lower three the step
	typedef enum logic [5:0] {
		st_reset = 6'b000_000,
		st_if1 = 6'b000_001,
		st_if2 = 6'b000_010,
		st_update_pc = 6'b000_011,
		st_mov_imm = 6'b001_000,
		st_mov_1 = 6'b010_000, // mov shifted register and mvn
		st_mov_2 = 6'b010_001,
		st_mov_3 = 6'b010_010,
		st_alu_1 = 6'b011_000, // add and and
		st_alu_2 = 6'b011_001,
		st_alu_3 = 6'b011_010,
		st_alu_4 = 6'b011_011,
		st_ldr_1 = 6'b101_000,
		st_ldr_2 = 6'b101_001,
		st_ldr_3 = 6'b101_010,
		st_ldr_4 = 6'b101_011,
		st_ldr_5 = 6'b101_100,
		st_str_1 = 6'b110_000,
		st_str_2 = 6'b110_001,
		st_str_3 = 6'b110_010,
		st_str_4 = 6'b110_011,
		st_str_5 = 6'b110_100,
		st_str_6 = 6'b110_101,
		st_halt = 6'b111_000
	} state_t;

	typedef enum logic [2:0] {
		nsel_none = 3'b000,
		nsel_rn = 3'b001,
		nsel_rd = 3'b010,
		nsel_rm = 3'b100
	} nsel_t;

	typedef enum logic [3:0] {
		vsel_none = 4'b0000,
		vsel_c = 4'b0001,
		vsel_pc = 4'b0010,
		vsel_imm = 4'b0100,
		vsel_mem = 4'b1000
	} vsel_t;

	typedef struct packed {
		opcode_t opcode;
		logic [1:0] op;
		alu_op_t alu_op;
		shift_t shift;
		word_t sximm5;
		word_t sximm8;
		reg_idx_t rnum; // one index serves read and write
	} decode_t;

	typedef struct packed {
		nsel_t nsel;
		vsel_t vsel;
		logic loada;
		logic loadb;
		logic loadc;
		logic asel; // 1 forces the a operand to zero
		logic bsel; // 1 picks sximm5 for the b operand
		logic write;
	} dp_ctrl_t;

	typedef struct packed {
		logic load_ir;
		logic load_pc;
		logic reset_pc;
		logic addr_sel; // 1 puts the pc on the memory address
		logic load_addr;
	} fetch_ctrl_t;

endpackage

/* rtl/fetch_unit.sv */
// instruction register, program counter, data address register and memory address select
`timescale 1ns/10ps

module fetch_unit #(
	parameter int addr_w = 9
) (
	input logic clk,
	input logic reset,
	input cpu_pkg::fetch_ctrl_t fctl,
	input cpu_pkg::word_t read_data,
	input cpu_pkg::word_t data_addr,
	output cpu_pkg::word_t instr,
	output logic [addr_w-1:0] pc,
	output logic [addr_w-1:0] mem_addr
);

	logic [addr_w-1:0] next_pc;
	logic [addr_w-1:0] data_addr_q;

	assign next_pc = fctl.reset_pc ? '0 : pc + 1'b1; // clear on reset or halt, else step

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else if (fctl.load_pc) begin
			pc <= next_pc;
		end
	end

	always_ff @(posedge clk) begin
		if (fctl.load_ir) begin
			instr <= read_data; // word fetched in if2
		end
	end

	always_ff @(posedge clk) begin
		if (fctl.load_addr) begin
			data_addr_q <= data_addr[addr_w-1:0]; // low bits of the computed sum
		end
	end

	assign mem_addr = fctl.addr_sel ? pc : data_addr_q;

	// clearing the pc is only meaningful together with its load enable
	a_reset_pc_with_load: assert property (
		@(posedge clk) disable iff (reset)
		fctl.reset_pc |-> fctl.load_pc
	);

endmodule

/* rtl/instr_decoder.sv */
// instruction field split, immediate sign extension and register index select
`timescale 1ns/10ps

module instr_decoder (
	input cpu_pkg::word_t instr,
	input cpu_pkg::nsel_t nsel,
	output cpu_pkg::decode_t dec
);

	cpu_pkg::opcode_t opcode;
	logic mem_instr;

	assign opcode = cpu_pkg::opcode_t'(instr[15:13]);
	assign mem_instr = (opcode == cpu_pkg::opc_load) || (opcode == cpu_pkg::opc_store);

	always_comb begin
		dec.opcode = opcode;
		dec.op = instr[12:11];
		dec.alu_op = cpu_pkg::alu_op_t'(instr[12:11]);
		dec.sximm5 = {{11{instr[4]}}, instr[4:0]};
		dec.sximm8 = {{8{instr[7]}}, instr[7:0]};
		// in ldr and str the shift bits belong to imm5
		if (mem_instr) begin
			dec.shift = cpu_pkg::sh_none;
		end else begin
			dec.shift = cpu_pkg::shift_t'(instr[4:3]);
		end
		case (nsel)
			cpu_pkg::nsel_rn: dec.rnum = instr[10:8];
			cpu_pkg::nsel_rd: dec.rnum = instr[7:5];
			cpu_pkg::nsel_rm: dec.rnum = instr[2:0];
			default: dec.rnum = '0; // nsel_none
		endcase
	end

endmodule

/* controller/cpu_controller.sv */
// instruction state machine with fetch, datapath and memory command outputs
`timescale 1ns/10ps

module cpu_controller (
	input logic clk,
	input logic reset,
	input cpu_pkg::decode_t dec,
	output cpu_pkg::fetch_ctrl_t fctl,
	output cpu_pkg::dp_ctrl_t dctl,
	output cpu_pkg::mem_cmd_t mem_cmd
);

	cpu_pkg::state_t state;
	cpu_pkg::state_t next_state;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= cpu_pkg::st_reset;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		case (state)
			cpu_pkg::st_reset: next_state = cpu_pkg::st_if1;
			cpu_pkg::st_if1: next_state = cpu_pkg::st_if2;
			cpu_pkg::st_if2: next_state = cpu_pkg::st_update_pc;
			cpu_pkg::st_update_pc: begin
				case ({dec.opcode, dec.op})
					{cpu_pkg::opc_move, 2'b10}: next_state = cpu_pkg::st_mov_imm;
					{cpu_pkg::opc_move, 2'b00}: next_state = cpu_pkg::st_mov_1;
					{cpu_pkg::opc_alu, 2'b00}: next_state = cpu_pkg::st_alu_1; // add
					{cpu_pkg::opc_alu, 2'b10}: next_state = cpu_pkg::st_alu_1; // and
					{cpu_pkg::opc_alu, 2'b11}: next_state = cpu_pkg::st_mov_1; // mvn
					{cpu_pkg::opc_load, 2'b00}: next_state = cpu_pkg::st_ldr_1;
					{cpu_pkg::opc_store, 2'b00}: next_state = cpu_pkg::st_str_1;
					{cpu_pkg::opc_halt, 2'b00}: next_state = cpu_pkg::st_halt;
					default: next_state = cpu_pkg::st_if1; // unknown pattern, skip it
				endcase
			end
			cpu_pkg::st_mov_1: next_state = cpu_pkg::st_mov_2;
			cpu_pkg::st_mov_2: next_state = cpu_pkg::st_mov_3;
			cpu_pkg::st_alu_1: next_state = cpu_pkg::st_alu_2;
			cpu_pkg::st_alu_2: next_state = cpu_pkg::st_alu_3;
			cpu_pkg::st_alu_3: next_state = cpu_pkg::st_alu_4;
			cpu_pkg::st_ldr_1: next_state = cpu_pkg::st_ldr_2;
			cpu_pkg::st_ldr_2: next_state = cpu_pkg::st_ldr_3;
			cpu_pkg::st_ldr_3: next_state = cpu_pkg::st_ldr_4;
			cpu_pkg::st_ldr_4: next_state = cpu_pkg::st_ldr_5;
			cpu_pkg::st_str_1: next_state = cpu_pkg::st_str_2;
			cpu_pkg::st_str_2: next_state = cpu_pkg::st_str_3;
			cpu_pkg::st_str_3: next_state = cpu_pkg::st_str_4;
			cpu_pkg::st_str_4: next_state = cpu_pkg::st_str_5;
			cpu_pkg::st_str_5: next_state = cpu_pkg::st_str_6;
			cpu_pkg::st_halt: next_state = cpu_pkg::st_halt; // stays until reset
			default: next_state = cpu_pkg::st_if1; // last step of every instruction
		endcase
	end

	always_comb begin
		fctl = '0;
		dctl = '0;
		mem_cmd = cpu_pkg::mem_none;
		case (state)
			cpu_pkg::st_reset, cpu_pkg::st_halt: begin
				fctl.reset_pc = 1'b1;
				fctl.load_pc = 1'b1;
				fctl.addr_sel = 1'b1; // address bus rests on pc 0
			end
			cpu_pkg::st_if1: begin
				fctl.addr_sel = 1'b1;
				mem_cmd = cpu_pkg::mem_read;
			end
			cpu_pkg::st_if2: begin
				fctl.addr_sel = 1'b1;
				fctl.load_ir = 1'b1;
				mem_cmd = cpu_pkg::mem_read;
			end
			cpu_pkg::st_update_pc: fctl.load_pc = 1'b1;
			cpu_pkg::st_mov_imm: begin
				dctl.nsel = cpu_pkg::nsel_rn; // destination sits in the rn field
				dctl.vsel = cpu_pkg::vsel_imm;
				dctl.write = 1'b1;
			end
			cpu_pkg::st_mov_1, cpu_pkg::st_alu_2: begin
				dctl.nsel = cpu_pkg::nsel_rm;
				dctl.loadb = 1'b1;
			end
			cpu_pkg::st_mov_2: begin
				dctl.asel = 1'b1; // zero plus shifted b, or not of it
				dctl.loadc = 1'b1;
			end
			cpu_pkg::st_alu_1, cpu_pkg::st_ldr_1, cpu_pkg::st_str_1: begin
				dctl.nsel = cpu_pkg::nsel_rn;
				dctl.loada = 1'b1;
			end
			cpu_pkg::st_alu_3: dctl.loadc = 1'b1;
			cpu_pkg::st_mov_3, cpu_pkg::st_alu_4: begin
				dctl.nsel = cpu_pkg::nsel_rd;
				dctl.vsel = cpu_pkg::vsel_c;
				dctl.write = 1'b1;
			end
			cpu_pkg::st_ldr_2, cpu_pkg::st_str_2: begin
				dctl.bsel = 1'b1; // rn plus sximm5
				dctl.loadc = 1'b1;
			end
			cpu_pkg::st_ldr_3: fctl.load_addr = 1'b1;
			cpu_pkg::st_ldr_4: mem_cmd = cpu_pkg::mem_read;
			cpu_pkg::st_ldr_5: begin
				mem_cmd = cpu_pkg::mem_read;
				dctl.nsel = cpu_pkg::nsel_rd;
				dctl.vsel = cpu_pkg::vsel_mem;
				dctl.write = 1'b1;
			end
			cpu_pkg::st_str_3: begin
				fctl.load_addr = 1'b1;
				dctl.nsel = cpu_pkg::nsel_rd;
				dctl.loadb = 1'b1;
			end
			cpu_pkg::st_str_4: begin
				dctl.asel = 1'b1; // c becomes rd for the store
				dctl.loadc = 1'b1;
			end
			cpu_pkg::st_str_5, cpu_pkg::st_str_6: mem_cmd = cpu_pkg::mem_write;
			default: mem_cmd = cpu_pkg::mem_none;
		endcase
	end

	// stores must go to the data address, never to the instruction address
	a_no_write_at_pc: assert property (
		@(posedge clk) disable iff (reset)
		!(mem_cmd == cpu_pkg::mem_write && fctl.addr_sel)
	);

	a_state_legal: assert property (
		@(posedge clk) disable iff (reset)
		state inside {cpu_pkg::st_reset, cpu_pkg::st_if1, cpu_pkg::st_if2,
			cpu_pkg::st_update_pc, cpu_pkg::st_mov_imm, cpu_pkg::st_mov_1,
			cpu_pkg::st_mov_2, cpu_pkg::st_mov_3, cpu_pkg::st_alu_1,
			cpu_pkg::st_alu_2, cpu_pkg::st_alu_3, cpu_pkg::st_alu_4,
			cpu_pkg::st_ldr_1, cpu_pkg::st_ldr_2, cpu_pkg::st_ldr_3,
			cpu_pkg::st_ldr_4, cpu_pkg::st_ldr_5, cpu_pkg::st_str_1,
			cpu_pkg::st_str_2, cpu_pkg::st_str_3, cpu_pkg::st_str_4,
			cpu_pkg::st_str_5, cpu_pkg::st_str_6, cpu_pkg::st_halt}
	);

endmodule

/* datapath/reg_file.sv */
// register file of eight words, one write port and one combinational read port
`timescale 1ns/10ps

module reg_file (
	input logic clk,
	input logic write,
	input cpu_pkg::reg_idx_t wnum,
	input cpu_pkg::reg_idx_t rnum,
	input cpu_pkg::word_t wdata,
	output cpu_pkg::word_t rdata
);

	cpu_pkg::word_t regs [8];

	always_ff @(posedge clk) begin
		if (write) begin
			regs[wnum] <= wdata;
		end
	end

	assign rdata = regs[rnum]; // old value until the write edge

endmodule

/* datapath/alu_shifter.sv */
// one-position shifter on the b operand followed by the alu
`timescale 1ns/10ps

module alu_shifter (
	input cpu_pkg::word_t a,
	input cpu_pkg::word_t b,
	input cpu_pkg::shift_t shift,
	input cpu_pkg::alu_op_t alu_op,
	output cpu_pkg::word_t y
);

	cpu_pkg::word_t b_sh;

	always_comb begin
		case (shift)
			cpu_pkg::sh_lsl1: b_sh = {b[cpu_pkg::word_w-2:0], 1'b0};
			cpu_pkg::sh_lsr1: b_sh = {1'b0, b[cpu_pkg::word_w-1:1]};
			cpu_pkg::sh_asr1: b_sh = {b[cpu_pkg::word_w-1], b[cpu_pkg::word_w-1:1]};
			default: b_sh = b; // sh_none
		endcase
	end

	always_comb begin
		case (alu_op)
			cpu_pkg::alu_add, cpu_pkg::alu_cmp: y = a + b_sh; // pass when a is zero
			cpu_pkg::alu_and: y = a & b_sh;
			cpu_pkg::alu_not: y = ~b_sh;
			default: y = a + b_sh;
		endcase
	end

endmodule

/* datapath/datapath.sv */
// operand registers a, b, c with writeback select, register file and alu
`timescale 1ns/10ps

module datapath #(
	parameter int addr_w = 9
) (
	input logic clk,
	input cpu_pkg::dp_ctrl_t dctl,
	input cpu_pkg::decode_t dec,
	input cpu_pkg::word_t read_data,
	input logic [addr_w-1:0] pc,
	output cpu_pkg::word_t datapath_out
);

	cpu_pkg::word_t a_q;
	cpu_pkg::word_t b_q;
	cpu_pkg::word_t c_q;
	cpu_pkg::word_t rdata;
	cpu_pkg::word_t wdata;
	cpu_pkg::word_t alu_a;
	cpu_pkg::word_t alu_b;
	cpu_pkg::word_t alu_y;

	always_comb begin
		case (dctl.vsel)
			cpu_pkg::vsel_pc: wdata = cpu_pkg::word_t'(pc); // zero extended
			cpu_pkg::vsel_imm: wdata = dec.sximm8;
			cpu_pkg::vsel_mem: wdata = read_data;
			default: wdata = c_q;
		endcase
	end

	reg_file u_reg_file (
		.clk(clk),
		.write(dctl.write),
		.wnum(dec.rnum),
		.rnum(dec.rnum),
		.wdata(wdata),
		.rdata(rdata)
	);

	always_ff @(posedge clk) begin
		if (dctl.loada) begin
			a_q <= rdata;
		end
		if (dctl.loadb) begin
			b_q <= rdata;
		end
		if (dctl.loadc) begin
			c_q <= alu_y;
		end
	end

	assign alu_a = dctl.asel ? '0 : a_q;
	assign alu_b = dctl.bsel ? dec.sximm5 : b_q;

	// the decoder already clears the shift for ldr and str, so the offset is never shifted
	alu_shifter u_alu (
		.a(alu_a),
		.b(alu_b),
		.shift(dec.shift),
		.alu_op(dec.alu_op),
		.y(alu_y)
	);

	assign datapath_out = c_q;

	// a register write must name exactly one source
	a_vsel_onehot: assert property (
		@(posedge clk) dctl.write |-> $onehot(dctl.vsel)
	);

endmodule

/* rtl/cpu.sv */
// cpu top level connecting fetch unit, decoder, controller and datapath
`timescale 1ns/10ps

module cpu #(
	parameter int addr_w = 9
) (
	input logic clk,
	input logic reset,
	input cpu_pkg::word_t read_data,
	output cpu_pkg::mem_cmd_t mem_cmd,
	output logic [addr_w-1:0] mem_addr,
	output cpu_pkg::word_t datapath_out
);

	cpu_pkg::fetch_ctrl_t fctl;
	cpu_pkg::dp_ctrl_t dctl;
	cpu_pkg::decode_t dec;
	cpu_pkg::word_t instr;
	logic [addr_w-1:0] pc;

	fetch_unit #(.addr_w(addr_w)) u_fetch (
		.clk(clk),
		.reset(reset),
		.fctl(fctl),
		.read_data(read_data),
		.data_addr(datapath_out), // c register holds the load/store address
		.instr(instr),
		.pc(pc),
		.mem_addr(mem_addr)
	);

	instr_decoder u_decoder (
		.instr(instr),
		.nsel(dctl.nsel),
		.dec(dec)
	);

	cpu_controller u_controller (
		.clk(clk),
		.reset(reset),
		.dec(dec),
		.fctl(fctl),
		.dctl(dctl),
		.mem_cmd(mem_cmd)
	);

	datapath #(.addr_w(addr_w)) u_datapath (
		.clk(clk),
		.dctl(dctl),
		.dec(dec),
		.read_data(read_data),
		.pc(pc),
		.datapath_out(datapath_out)
	);

endmodule

/* testbench/cpu_ref.svh */
// instruction word assembly helpers and the instruction-set reference model
`ifndef CPU_REF_SVH
`define CPU_REF_SVH

cpu_pkg::word_t ref_mem [mem_words];
cpu_pkg::word_t ref_regs [8];

function automatic cpu_pkg::word_t mov_imm_word(input logic [2:0] rn, input logic [7:0] imm8);
	return {cpu_pkg::opc_move, 2'b10, rn, imm8}; // destination in the rn field
endfunction

function automatic cpu_pkg::word_t mov_reg_word(input logic [2:0] rd, input logic [2:0] rm,
		input logic [1:0] sh);
	return {cpu_pkg::opc_move, 2'b00, 3'b000, rd, sh, rm};
endfunction

// op 00 add, 10 and, 11 mvn
function automatic cpu_pkg::word_t alu_word(input logic [1:0] op, input logic [2:0] rn,
		input logic [2:0] rd, input logic [2:0] rm, input logic [1:0] sh);
	return {cpu_pkg::opc_alu, op, rn, rd, sh, rm};
endfunction

function automatic cpu_pkg::word_t ldr_word(input logic [2:0] rd, input logic [2:0] rn,
		input logic [4:0] imm5);
	return {cpu_pkg::opc_load, 2'b00, rn, rd, imm5};
endfunction

function automatic cpu_pkg::word_t str_word(input logic [2:0] rd, input logic [2:0] rn,
		input logic [4:0] imm5);
	return {cpu_pkg::opc_store, 2'b00, rn, rd, imm5};
endfunction

function automatic cpu_pkg::word_t halt_word();
	return {cpu_pkg::opc_halt, 13'b0};
endfunction

function automatic cpu_pkg::word_t shift_value(input cpu_pkg::word_t v, input logic [1:0] sh);
	case (sh)
		2'b01: return v << 1;
		2'b10: return v >> 1;
		2'b11: return cpu_pkg::word_t'($signed(v) >>> 1);
		default: return v;
	endcase
endfunction

// fetches from ref_mem like the cpu does, so the program runs from its own image
function automatic void run_reference();
	int pc;
	int steps;
	bit halted;
	cpu_pkg::word_t w;
	cpu_pkg::word_t opnd;
	cpu_pkg::word_t ea;
	pc = 0;
	steps = 0;
	halted = 1'b0;
	while (!halted && steps < 4 * mem_words) begin
		w = ref_mem[pc];
		pc = (pc + 1) % mem_words;
		steps++;
		opnd = shift_value(ref_regs[w[2:0]], w[4:3]);
		ea = ref_regs[w[10:8]] + {{11{w[4]}}, w[4:0]}; // rn plus sximm5
		case ({w[15:13], w[12:11]})
			5'b110_10: ref_regs[w[10:8]] = {{8{w[7]}}, w[7:0]};
			5'b110_00: ref_regs[w[7:5]] = opnd;
			5'b101_00: ref_regs[w[7:5]] = ref_regs[w[10:8]] + opnd;
			5'b101_10: ref_regs[w[7:5]] = ref_regs[w[10:8]] & opnd;
			5'b101_11: ref_regs[w[7:5]] = ~opnd;
			5'b011_00: ref_regs[w[7:5]] = ref_mem[ea[addr_w-1:0]];
			5'b100_00: ref_mem[ea[addr_w-1:0]] = ref_regs[w[7:5]];
			5'b111_00: halted = 1'b1;
			default: ; // unknown pattern is skipped
		endcase
	end
endfunction

`endif

/* testbench/cpu_tb.sv */
// testbench for the cpu: clock, reset, memory model, directed and random programs, checks
`timescale 1ns/10ps

module cpu_tb;

	localparam int addr_w = 9;
	localparam int mem_words = 1 << addr_w;
	localparam int halt_timeout = 5000;

	logic clk;
	logic reset;
	cpu_pkg::word_t read_data;
	cpu_pkg::mem_cmd_t mem_cmd;
	logic [addr_w-1:0] mem_addr;
	cpu_pkg::word_t datapath_out;

	cpu_pkg::word_t mem [mem_words];
	cpu_pkg::word_t image [mem_words]; // program and data for the next run
	int prog_len;

	logic [31:0] rng = 32'h269;
	string test_name;
	int errors = 0;
	int test_start_errors;
	int tests_run = 0;
	int tests_failed = 0;
	bit aborted = 1'b0;

	// monitor results of the current run
	bit seen_read;
	logic [addr_w-1:0] first_read_addr;
	logic [addr_w-1:0] max_read_addr;
	int write_cycles;

	`include "cpu_ref.svh"

	cpu #(.addr_w(addr_w)) DUT (
		.clk(clk),
		.reset(reset),
		.read_data(read_data),
		.mem_cmd(mem_cmd),
		.mem_addr(mem_addr),
		.datapath_out(datapath_out)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	assign read_data = (mem_cmd == cpu_pkg::mem_read) ? mem[mem_addr] : '0;

	always @(posedge clk) begin
		if (mem_cmd == cpu_pkg::mem_write) begin
			mem[mem_addr] <= datapath_out;
		end
	end

	always @(negedge clk) begin
		if (reset) begin
			assert (mem_cmd == cpu_pkg::mem_none) else begin
				$display("error in %s: mem_cmd is not none during reset", test_name);
				errors++;
			end
		end else begin
			if (mem_cmd == cpu_pkg::mem_read) begin
				if (!seen_read) begin
					seen_read = 1'b1;
					first_read_addr = mem_addr;
				end
				if (mem_addr > max_read_addr) begin
					max_read_addr = mem_addr;
				end
			end
			if (mem_cmd == cpu_pkg::mem_write) begin
				write_cycles++;
			end
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	// every address bit changes the word
	function automatic cpu_pkg::word_t fill_word(input int a);
		return cpu_pkg::word_t'((a * 32'h9e37) ^ 32'h5a5a);
	endfunction

	function automatic void clear_image();
		for (int a = 0; a < mem_words; a++) begin
			image[a] = fill_word(a);
		end
		prog_len = 0;
	endfunction

	function automatic void emit(input cpu_pkg::word_t w);
		image[prog_len] = w;
		prog_len++;
	endfunction

	// destinations stay in r0 to r6, r7 keeps the data base address
	function automatic cpu_pkg::word_t random_instr();
		logic [31:0] r;
		logic [2:0] d;
		r = next_rand();
		d = 3'(r[7:0] % 7);
		case (r[31:24] % 7)
			0: return mov_imm_word(d, r[23:16]);
			1: return mov_reg_word(d, r[13:11], r[15:14]);
			2: return alu_word(2'b00, r[10:8], d, r[13:11], r[15:14]);
			3: return alu_word(2'b10, r[10:8], d, r[13:11], r[15:14]);
			4: return alu_word(2'b11, 3'd0, d, r[13:11], r[15:14]);
			5: return ldr_word(d, 3'd7, r[20:16]);
			default: return str_word(d, 3'd7, r[20:16]);
		endcase
	endfunction

	task automatic check_word(input int addr, input cpu_pkg::word_t exp,
			input cpu_pkg::word_t act);
		assert (act === exp) else begin
			$display("mismatch %s: mem[%0d] expected %h actual %h", test_name, addr, exp, act);
			errors++;
		end
	endtask

	task automatic wait_for_halt(output bit halted);
		int cycles;
		int quiet;
		halted = 1'b0;
		cycles = 0;
		quiet = 0;
		while (!halted && cycles < halt_timeout) begin
			@(negedge clk);
			cycles++;
			if (mem_addr == '0 && mem_cmd == cpu_pkg::mem_none) begin
				quiet++;
			end else begin
				quiet = 0;
			end
			if (quiet >= 10) begin
				halted = 1'b1;
			end
		end
	endtask

	// load the image, reset, run to halt and compare the whole memory
	task automatic run_image();
		bit halted;
		@(posedge clk);
		#2;
		reset = 1'b1;
		for (int a = 0; a < mem_words; a++) begin
			mem[a] = image[a];
			ref_mem[a] = image[a];
		end
		for (int r = 0; r < 8; r++) begin
			ref_regs[r] = '0;
		end
		seen_read = 1'b0;
		first_read_addr = '0;
		max_read_addr = '0;
		write_cycles = 0;
		repeat (4) @(posedge clk);
		#2;
		reset = 1'b0;
		wait_for_halt(halted);
		if (!halted) begin
			$display("error in %s: HALT not reached within %0d cycles", test_name, halt_timeout);
			errors++;
			aborted = 1'b1;
		end else begin
			run_reference();
			for (int a = 0; a < mem_words; a++) begin
				check_word(a, ref_mem[a], mem[a]);
			end
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_start_errors = errors;
		clear_image();
	endtask

	task automatic end_test();
		tests_run++;
		if (errors == test_start_errors) begin
			$display("test %s: ok", test_name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", test_name, errors - test_start_errors);
		end
	endtask

	task automatic test_reset_fetch();
		start_test("reset_fetch");
		emit(mov_imm_word(3'd1, 8'h03));
		emit(mov_imm_word(3'd0, 8'h00));
		emit(str_word(3'd1, 3'd0, 5'h1f)); // address 511
		emit(halt_word());
		run_image();
		if (!aborted) begin
			assert (seen_read) else begin
				$display("error in %s: no memory read after reset", test_name);
				errors++;
			end
			assert (first_read_addr == '0) else begin
				$display("mismatch %s: first fetch address expected 0 actual %0d",
					test_name, first_read_addr);
				errors++;
			end
		end
		end_test();
	endtask

	task automatic test_mov_imm();
		logic [7:0] vals [8] = '{8'h00, 8'h01, 8'h7f, 8'h80, 8'hff, 8'h55, 8'haa, 8'h64};
		start_test("mov_imm");
		for (int i = 0; i < 8; i++) begin
			emit(mov_imm_word(3'(i), vals[i]));
		end
		for (int i = 0; i < 8; i++) begin
			emit(str_word(3'(i), 3'd0, 5'(i - 16))); // r0 is zero, addresses 496 up
		end
		emit(halt_word());
		run_image();
		if (!aborted) begin
			for (int i = 0; i < 8; i++) begin
				check_word(496 + i, {{8{vals[i][7]}}, vals[i]}, mem[496 + i]);
			end
		end
		end_test();
	endtask

	task automatic test_alu_shifts();
		logic [31:0] r;
		logic [1:0] ops [3] = '{2'b00, 2'b10, 2'b11};
		start_test("alu_shifts");
		emit(mov_imm_word(3'd7, 8'h90)); // base 400
		for (int i = 0; i < 7; i++) begin
			image[400 + i] = cpu_pkg::word_t'(next_rand());
			emit(ldr_word(3'(i), 3'd7, 5'(i)));
		end
		for (int k = 0; k < 12; k++) begin
			r = next_rand();
			emit(alu_word(ops[k / 4], r[2:0], 3'(r[15:8] % 7), r[18:16], 2'(k % 4)));
			emit(str_word(3'(r[15:8] % 7), 3'd7, 5'(k - 16)));
		end
		emit(halt_word());
		run_image();
		end_test();
	endtask

	task automatic test_ldr_copy();
		cpu_pkg::word_t src [5];
		start_test("ldr_copy");
		emit(mov_imm_word(3'd7, 8'h90)); // source base 400
		emit(mov_imm_word(3'd6, 8'hb0)); // destination base 432
		for (int i = 0; i < 5; i++) begin
			src[i] = cpu_pkg::word_t'(next_rand());
			image[401 + i] = src[i];
			emit(ldr_word(3'(i), 3'd7, 5'(i + 1)));
		end
		for (int i = 0; i < 5; i++) begin
			emit(str_word(3'(i), 3'd6, 5'(2 * i - 5)));
		end
		emit(halt_word());
		run_image();
		if (!aborted) begin
			for (int i = 0; i < 5; i++) begin
				check_word(427 + 2 * i, src[i], mem[427 + 2 * i]);
			end
		end
		end_test();
	endtask

	task automatic test_halt();
		int halt_addr;
		start_test("halt");
		emit(mov_imm_word(3'd1, 8'h05));
		emit(mov_imm_word(3'd2, 8'hfd));
		emit(mov_imm_word(3'd7, 8'h90));
		emit(str_word(3'd1, 3'd7, 5'd0));
		emit(str_word(3'd2, 3'd7, 5'd1));
		halt_addr = prog_len;
		emit(halt_word());
		emit(str_word(3'd1, 3'd7, 5'd2)); // must never run
		emit(mov_imm_word(3'd3, 8'h11));
		emit(str_word(3'd3, 3'd7, 5'd3));
		run_image();
		if (!aborted) begin
			assert (max_read_addr == halt_addr) else begin
				$display("error in %s: fetched address %0d beyond HALT at %0d",
					test_name, max_read_addr, halt_addr);
				errors++;
			end
			assert (write_cycles == 4) else begin
				$display("mismatch %s: write cycles expected 4 actual %0d",
					test_name, write_cycles);
				errors++;
			end
		end
		end_test();
	endtask

	task automatic test_random(input int n);
		start_test($sformatf("random_%0d", n));
		emit(mov_imm_word(3'd7, 8'h90));
		for (int i = 0; i < 7; i++) begin
			emit(mov_imm_word(3'(i), next_rand() & 8'hff));
		end
		for (int a = 384; a < 416; a++) begin
			image[a] = cpu_pkg::word_t'(next_rand());
		end
		for (int k = 0; k < 14; k++) begin
			emit(random_instr());
		end
		for (int i = 0; i < 8; i++) begin
			emit(str_word(3'(i), 3'd7, 5'(i - 16)));
		end
		emit(halt_word());
		run_image();
		end_test();
	endtask

	initial begin
		reset = 1'b1;
		test_name = "startup";
		test_reset_fetch();
		if (!aborted) test_mov_imm();
		if (!aborted) test_alu_shifts();
		if (!aborted) test_ldr_copy();
		if (!aborted) test_halt();
		for (int n = 0; n < 20; n++) begin
			if (!aborted) test_random(n);
		end
		$display("tests run %0d, passed %0d, failed %0d, errors %0d",
			tests_run, tests_run - tests_failed, tests_failed, errors);
		if (errors == 0 && !aborted) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

/* flist.f */
+incdir+testbench
common/cpu_pkg.sv
rtl/fetch_unit.sv
rtl/instr_decoder.sv
controller/cpu_controller.sv
datapath/reg_file.sv
datapath/alu_shifter.sv
datapath/datapath.sv
rtl/cpu.sv
testbench/cpu_tb.sv
